// File: xadc_stream_pkg.sv
`default_nettype none

package xadc_stream_pkg;

    // DRP address bus of the XADC
    typedef logic [6:0] xadc_drp_addr_t;

    // status registers of the two aux channels
    localparam xadc_drp_addr_t CURRENT_DRP_ADDR = 7'h14; // vaux4, current sensor
    localparam xadc_drp_addr_t VOLTAGE_DRP_ADDR = 7'h1c; // vaux12, voltage divider

    // DRP read word
    // either taken whole, or split into the 12-bit code over sub-LSB bits
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [11:0] code;     // conversion result, msb aligned
            logic [3:0]  sub_lsb;  // below converter resolution, ignored
        } conv;
    } xadc_do_u;

    // one stored sample, current code high and voltage code low
    localparam int SAMPLE_W = 24;

    // code byte + four payload bytes + 00 delimiter
    localparam int COBS_FRAME_LEN = 6;

endpackage

`default_nettype wire

// File: sample_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module sample_fifo #(
    parameter int FIFO_ADDR_W = 3
) (
    input  var logic                                 sys_clk,
    input  var logic                                 rst_n,
    input  var logic                                 push,
    input  var logic [xadc_stream_pkg::SAMPLE_W-1:0] push_word,
    input  var logic                                 pop,
    output var logic [xadc_stream_pkg::SAMPLE_W-1:0] pop_word,
    output var logic                                 full,
    output var logic                                 empty
);

    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    logic [xadc_stream_pkg::SAMPLE_W-1:0] mem [DEPTH];  // sample storage
    logic [FIFO_ADDR_W:0] wr_ptr;  // extra msb tells full from empty
    logic [FIFO_ADDR_W:0] rd_ptr;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (push)
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= push_word;
    end

    // show-ahead head word always on the output
    assign pop_word = mem[rd_ptr[FIFO_ADDR_W-1:0]];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                   (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    // packetizer must look at empty before popping
    assert property (@(posedge sys_clk) disable iff (!rst_n) pop |-> !empty)
        else $error("sample_fifo pop while empty");

    // poller drops the sample instead of pushing into a full fifo
    assert property (@(posedge sys_clk) disable iff (!rst_n) push |-> !full)
        else $error("sample_fifo push while full");

endmodule

`default_nettype wire

// File: xadc_drp_poller.sv
`default_nettype none
`timescale 1ns/1ns

module xadc_drp_poller #(
    parameter int FIFO_ADDR_W = 3
) (
    input  var logic                                 sys_clk,
    input  var logic                                 rst_n,
    input  var logic                                 xadc_eos,     // one-cycle end of sequence
    output var xadc_stream_pkg::xadc_drp_addr_t      xadc_daddr,
    output var logic                                 xadc_den,
    input  var logic                                 xadc_drdy,
    input  var logic [15:0]                          xadc_do,
    input  var logic                                 sample_pop,
    output var logic [xadc_stream_pkg::SAMPLE_W-1:0] sample_word,
    output var logic                                 sample_empty,
    output var logic                                 overrun       // sticky until reset
);

    // read sequencer states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CUR  = 2'd1;  // waiting on vaux4 drdy
    localparam logic [1:0] ST_VOLT = 2'd2;  // waiting on vaux12 drdy

    logic [1:0]  state;
    logic        rd_pending;  // den sent and drdy not yet back
    logic        push_req;    // sample complete this cycle
    logic        fifo_push;
    logic        fifo_full;
    logic [11:0] cur_code;    // vaux4 code held until vaux12 returns
    logic [xadc_stream_pkg::SAMPLE_W-1:0] push_word;

    xadc_stream_pkg::xadc_do_u do_word;

    assign do_word.raw = xadc_do;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            xadc_den   <= 1'b0;
            push_req   <= 1'b0;
            rd_pending <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            xadc_den <= 1'b0;  // strobes default low
            push_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (xadc_eos) begin  // eos outside idle is ignored
                        xadc_den <= 1'b1;
                        state    <= ST_CUR;
                    end
                end
                ST_CUR: begin
                    if (xadc_drdy) begin
                        xadc_den <= 1'b1;  // chain straight into the voltage read
                        state    <= ST_VOLT;
                    end
                end
                ST_VOLT: begin
                    if (xadc_drdy) begin
                        push_req <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (xadc_den)
                rd_pending <= 1'b1;
            else if (xadc_drdy)
                rd_pending <= 1'b0;

            if (push_req && fifo_full)
                overrun <= 1'b1;  // sample lost
        end
    end

    // DRP address and captured codes
    always_ff @(posedge sys_clk) begin
        if (state == ST_IDLE && xadc_eos)
            xadc_daddr <= xadc_stream_pkg::CURRENT_DRP_ADDR;
        if (state == ST_CUR && xadc_drdy) begin
            xadc_daddr <= xadc_stream_pkg::VOLTAGE_DRP_ADDR;
            cur_code   <= do_word.conv.code;
        end
        if (state == ST_VOLT && xadc_drdy)
            push_word <= {cur_code, do_word.conv.code};  // current code high and voltage low
    end

    assign fifo_push = push_req && !fifo_full;  // drop on full

    sample_fifo #(
        .FIFO_ADDR_W(FIFO_ADDR_W)
    ) fifo0 (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .push     (fifo_push),
        .push_word(push_word),
        .pop      (sample_pop),
        .pop_word (sample_word),
        .full     (fifo_full),
        .empty    (sample_empty)
    );

    // only one DRP read in flight
    assert property (@(posedge sys_clk) disable iff (!rst_n) xadc_den |-> !rd_pending)
        else $error("xadc_den raised with a DRP read outstanding");

    // XADC only answers what was asked
    assert property (@(posedge sys_clk) disable iff (!rst_n) xadc_drdy |-> state != ST_IDLE)
        else $error("xadc_drdy seen with no read in progress");

endmodule

`default_nettype wire

// File: ft_write_port.sv
`default_nettype none
`timescale 1ns/1ns

module ft_write_port (
    input  var logic       sys_clk,
    input  var logic       rst_n,
    input  var logic       byte_load,   // 1 cycle, only while byte_ready
    input  var logic [7:0] byte_data,
    output var logic       byte_ready,
    input  var logic       ftdi_txe_n,  // low when the FTDI can take a byte
    output var logic       ftdi_wr_n,
    output var logic [7:0] ftdi_data
);

    logic hold_valid;  // holding register has a byte for the FTDI
    logic drain;       // byte leaves on this edge

    assign drain      = hold_valid && !ftdi_txe_n;
    assign byte_ready = !hold_valid || drain;  // free now or free after this edge

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else begin
            if (byte_load)
                hold_valid <= 1'b1;  // back to back, wr_n stays low
            else if (drain)
                hold_valid <= 1'b0;
        end
    end

    // data register, loaded straight onto the bus
    always_ff @(posedge sys_clk) begin
        if (byte_load)
            ftdi_data <= byte_data;
    end

    assign ftdi_wr_n = !hold_valid;

    // bus must not move while the FTDI is stalling a write
    assert property (@(posedge sys_clk) disable iff (!rst_n)
        (!ftdi_wr_n && ftdi_txe_n) |=> $stable(ftdi_data))
        else $error("ftdi_data changed during a stalled write");

    // packetizer keeps to byte_ready
    assert property (@(posedge sys_clk) disable iff (!rst_n) byte_load |-> byte_ready)
        else $error("byte_load while holding register busy");

endmodule

`default_nettype wire

// File: cobs_packetizer.sv
`default_nettype none
`timescale 1ns/1ns

module cobs_packetizer (
    input  var logic                                 sys_clk,
    input  var logic                                 rst_n,
    input  var logic                                 sample_empty,
    output var logic                                 sample_pop,
    input  var logic [xadc_stream_pkg::SAMPLE_W-1:0] sample_word,  // show-ahead head
    input  var logic                                 byte_ready,
    output var logic                                 byte_load,
    output var logic [7:0]                           byte_data
);

    localparam int FRAME_LEN = xadc_stream_pkg::COBS_FRAME_LEN;
    localparam logic [2:0] LAST_IDX = 3'(FRAME_LEN - 1);  // delimiter slot

    logic        busy;          // frame in progress
    logic [2:0]  byte_cnt;      // next byte to hand to the port
    logic [11:0] cur_code;
    logic [11:0] volt_code;
    logic [7:0]  payload [4];
    logic [7:0]  enc     [FRAME_LEN];  // encoded frame of the head sample
    logic [7:0]  frame_q [FRAME_LEN];  // frame being sent

    assign cur_code  = sample_word[xadc_stream_pkg::SAMPLE_W-1 -: 12];
    assign volt_code = sample_word[11:0];

    // COBS over the four payload bytes
    always_comb begin : cobs_enc
        logic [2:0] next_zero;
        next_zero  = 3'd4;  // end of payload counts as a zero
        payload[0] = {4'h0, cur_code[11:8]};
        payload[1] = cur_code[7:0];
        payload[2] = {4'h0, volt_code[11:8]};
        payload[3] = volt_code[7:0];
        // walk back from the end so each zero knows where the next one is
        for (int j = 3; j >= 0; j--) begin
            if (payload[j] == 8'h00) begin
                enc[j+1]  = 8'(next_zero - 3'(j));  // distance to next zero or end
                next_zero = 3'(j);
            end else begin
                enc[j+1] = payload[j];
            end
        end
        enc[0]         = 8'(next_zero) + 8'd1;  // leading code byte
        enc[LAST_IDX]  = 8'h00;                 // delimiter
    end

    assign sample_pop = !busy && !sample_empty;  // idle and data waiting
    assign byte_load  = busy && byte_ready;
    assign byte_data  = frame_q[byte_cnt];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            byte_cnt <= 3'd0;
        end else begin
            if (sample_pop) begin
                busy     <= 1'b1;
                byte_cnt <= 3'd0;
            end else if (byte_load) begin
                if (byte_cnt == LAST_IDX) begin
                    busy     <= 1'b0;  // free to pop next cycle
                    byte_cnt <= 3'd0;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
        end
    end

    // frame captured in the pop cycle
    always_ff @(posedge sys_clk) begin
        if (sample_pop)
            frame_q <= enc;
    end

    // zero only ever marks the frame boundary
    assert property (@(posedge sys_clk) disable iff (!rst_n)
        byte_load |-> ((byte_data == 8'h00) == (byte_cnt == LAST_IDX)))
        else $error("zero byte inside COBS frame or nonzero delimiter");

endmodule

`default_nettype wire

// File: xadc_usb_stream.sv
`default_nettype none
`timescale 1ns/1ns

module xadc_usb_stream #(
    parameter int FIFO_ADDR_W = 3  // log2 of sample fifo depth
) (
    input  var logic                            sys_clk,
    input  var logic                            rst_n,
    // XADC DRP side
    input  var logic                            xadc_eos,
    output var xadc_stream_pkg::xadc_drp_addr_t xadc_daddr,
    output var logic                            xadc_den,
    input  var logic                            xadc_drdy,
    input  var logic [15:0]                     xadc_do,
    // FT245 sync write side
    input  var logic                            ftdi_txe_n,
    output var logic                            ftdi_wr_n,
    output var logic [7:0]                      ftdi_data,
    output var logic                            overrun
);

    logic                                 sample_pop;
    logic                                 sample_empty;
    logic [xadc_stream_pkg::SAMPLE_W-1:0] sample_word;
    logic                                 byte_ready;
    logic                                 byte_load;
    logic [7:0]                           byte_data;

    xadc_drp_poller #(
        .FIFO_ADDR_W(FIFO_ADDR_W)
    ) poller0 (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .xadc_eos    (xadc_eos),
        .xadc_daddr  (xadc_daddr),
        .xadc_den    (xadc_den),
        .xadc_drdy   (xadc_drdy),
        .xadc_do     (xadc_do),
        .sample_pop  (sample_pop),
        .sample_word (sample_word),
        .sample_empty(sample_empty),
        .overrun     (overrun)
    );

    cobs_packetizer packetizer0 (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .sample_empty(sample_empty),
        .sample_pop  (sample_pop),
        .sample_word (sample_word),
        .byte_ready  (byte_ready),
        .byte_load   (byte_load),
        .byte_data   (byte_data)
    );

    ft_write_port usb_port0 (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .byte_load (byte_load),
        .byte_data (byte_data),
        .byte_ready(byte_ready),
        .ftdi_txe_n(ftdi_txe_n),
        .ftdi_wr_n (ftdi_wr_n),
        .ftdi_data (ftdi_data)
    );

endmodule

`default_nettype wire

// File: tb_xadc_model.sv
`timescale 1ns/1ns

module tb_xadc_model #(
    parameter int SEED = 61708
) (
    input  var logic                            sys_clk,
    input  var logic                            rst_n,
    input  var logic                            eos_req,    // ask for one end of sequence
    input  var logic [11:0]                     cur_code,   // codes for that sequence
    input  var logic [11:0]                     volt_code,
    output var logic                            xadc_eos,
    input  var xadc_stream_pkg::xadc_drp_addr_t xadc_daddr,
    input  var logic                            xadc_den,
    output var logic                            xadc_drdy,
    output var logic [15:0]                     xadc_do
);

    logic [11:0] cur_q  [$];  // codes waiting for their DRP read
    logic [11:0] volt_q [$];
    int          seed = SEED;
    int          delay_left = 0;  // cycles until drdy
    logic        busy = 1'b0;     // read accepted, answer pending
    logic        eos_r = 1'b0;
    logic        drdy_r = 1'b0;
    logic [15:0] do_r = 16'h0000;
    xadc_stream_pkg::xadc_drp_addr_t addr_r;

    assign xadc_eos  = eos_r;
    assign xadc_drdy = drdy_r;
    assign xadc_do   = do_r;

    // next code of the addressed channel, msb aligned over a random nibble
    function automatic logic [15:0] read_word(input xadc_stream_pkg::xadc_drp_addr_t addr);
        logic [11:0] code;
        code = 12'hfff;
        if (addr == xadc_stream_pkg::CURRENT_DRP_ADDR && cur_q.size() > 0)
            code = cur_q.pop_front();
        else if (addr == xadc_stream_pkg::VOLTAGE_DRP_ADDR && volt_q.size() > 0)
            code = volt_q.pop_front();
        else
            $display("model at %0t: DRP read of address %h with no code queued", $time, addr);
        return {code, 4'($random(seed))};
    endfunction

    always @(posedge sys_clk) begin
        if (!rst_n) begin
            eos_r  <= 1'b0;
            drdy_r <= 1'b0;
            busy   <= 1'b0;
            cur_q.delete();
            volt_q.delete();
        end else begin
            eos_r  <= eos_req;  // eos one cycle after the request
            drdy_r <= 1'b0;
            if (eos_req) begin
                cur_q.push_back(cur_code);
                volt_q.push_back(volt_code);
            end
            if (xadc_den) begin
                busy       <= 1'b1;
                addr_r     <= xadc_daddr;
                delay_left <= 1 + int'($unsigned($random(seed)) % 6);  // 1 to 6 cycles
            end else if (busy) begin
                if (delay_left == 1) begin
                    drdy_r <= 1'b1;
                    do_r   <= read_word(addr_r);
                    busy   <= 1'b0;
                end else begin
                    delay_left <= delay_left - 1;
                end
            end
        end
    end

endmodule

// File: tb_xadc_usb_stream.sv
`timescale 1ns/1ns

module tb_xadc_usb_stream;

    localparam int FIFO_ADDR_W = 3;
    localparam int DEPTH       = 2 ** FIFO_ADDR_W;
    localparam int FRAME_LEN   = xadc_stream_pkg::COBS_FRAME_LEN;
    localparam int SEED        = 61708;
    localparam int WAIT_LIMIT  = 3000;  // cycles per wait loop

    logic        sys_clk = 1'b0;
    logic        rst_n;
    logic        xadc_eos;
    logic        xadc_den;
    logic        xadc_drdy;
    logic [15:0] xadc_do;
    logic        ftdi_txe_n = 1'b0;
    logic        ftdi_wr_n;
    logic [7:0]  ftdi_data;
    logic        overrun;
    logic        eos_req;
    logic [11:0] cur_code;
    logic [11:0] volt_code;
    logic [1:0]  txe_mode;           // 0 ready, 1 stalled, 2 random
    logic        expect_volt = 1'b0; // next den goes to vaux12
    logic        aborted;            // a wait timed out, later waits fall through
    logic [7:0]  exp_q [$];          // expected bytes, oldest first
    int          seed = SEED;
    int          txe_seed = SEED;
    int          err_count;
    int          byte_err_count = 0;
    int          drp_err_count = 0;
    int          timeout_count;
    int          bytes_seen = 0;
    int          drdy_count = 0;
    xadc_stream_pkg::xadc_drp_addr_t xadc_daddr;

    always #50 sys_clk = ~sys_clk;

    xadc_usb_stream #(.FIFO_ADDR_W(FIFO_ADDR_W)) dut0 (
        .sys_clk(sys_clk), .rst_n(rst_n),
        .xadc_eos(xadc_eos), .xadc_daddr(xadc_daddr), .xadc_den(xadc_den),
        .xadc_drdy(xadc_drdy), .xadc_do(xadc_do),
        .ftdi_txe_n(ftdi_txe_n), .ftdi_wr_n(ftdi_wr_n), .ftdi_data(ftdi_data),
        .overrun(overrun)
    );

    tb_xadc_model #(.SEED(SEED)) model0 (
        .sys_clk(sys_clk), .rst_n(rst_n), .eos_req(eos_req),
        .cur_code(cur_code), .volt_code(volt_code), .xadc_eos(xadc_eos),
        .xadc_daddr(xadc_daddr), .xadc_den(xadc_den),
        .xadc_drdy(xadc_drdy), .xadc_do(xadc_do)
    );

    // expected frame, byte 0 in the top bits
    function automatic logic [8*FRAME_LEN-1:0] cobs_frame(input logic [11:0] cur,
                                                          input logic [11:0] volt);
        logic [7:0] data [4];
        logic [7:0] out  [FRAME_LEN];
        logic [7:0] code;
        int         code_pos;
        int         wr_pos;
        logic [8*FRAME_LEN-1:0] frame;
        data = '{{4'h0, cur[11:8]}, cur[7:0], {4'h0, volt[11:8]}, volt[7:0]};
        code_pos = 0;
        wr_pos   = 1;
        code     = 8'd1;
        for (int i = 0; i < 4; i++) begin
            if (data[i] == 8'h00) begin
                out[code_pos] = code;  // close the run at this zero
                code_pos = wr_pos;
                code     = 8'd1;
            end else begin
                out[wr_pos] = data[i];
                code++;
            end
            wr_pos++;
        end
        out[code_pos]    = code;
        out[FRAME_LEN-1] = 8'h00;  // delimiter
        for (int k = 0; k < FRAME_LEN; k++)
            frame[8*(FRAME_LEN-1-k) +: 8] = out[k];
        return frame;
    endfunction

    task automatic note_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        timeout_count++;
        aborted = 1'b1;
    endtask

    // queue the frame, pulse eos, wait until both DRP reads are answered
    task automatic issue_sample(input logic [11:0] cur, input logic [11:0] volt);
        logic [8*FRAME_LEN-1:0] frame;
        int target;
        int cycles;
        frame = cobs_frame(cur, volt);
        for (int k = 0; k < FRAME_LEN; k++)
            exp_q.push_back(frame[8*(FRAME_LEN-1-k) +: 8]);
        target = drdy_count + 2;
        cycles = 0;
        @(posedge sys_clk);
        cur_code  <= cur;
        volt_code <= volt;
        eos_req   <= 1'b1;
        @(posedge sys_clk);
        eos_req <= 1'b0;
        while (drdy_count < target && !aborted) begin
            @(posedge sys_clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                note_timeout("DRP read pair never completed");
        end
    endtask

    task automatic wait_queue_below(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q.size() >= limit && !aborted) begin
            @(posedge sys_clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                note_timeout("expected bytes never left on the FTDI bus");
        end
    endtask

    task automatic wait_quiet(input int span);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < span && !aborted) begin
            @(posedge sys_clk);
            quiet = ftdi_wr_n ? quiet + 1 : 0;
            cycles++;
            if (cycles > WAIT_LIMIT)
                note_timeout("FTDI write strobe never went idle");
        end
    endtask

    always @(posedge sys_clk) begin
        case (txe_mode)
            2'd0:    ftdi_txe_n <= 1'b0;
            2'd1:    ftdi_txe_n <= 1'b1;
            default: ftdi_txe_n <= 1'($random(txe_seed));
        endcase
    end

    // byte collector, one byte per edge with wr_n and txe_n low
    always @(posedge sys_clk) begin
        if (rst_n && !ftdi_wr_n && !ftdi_txe_n) begin
            bytes_seen++;
            if (exp_q.size() == 0) begin
                byte_err_count++;
                $display("error at %0t: byte %h written with no frame expected", $time, ftdi_data);
            end else begin
                if (ftdi_data !== exp_q[0]) begin
                    byte_err_count++;
                    $display("error at %0t: frame byte %h, expected %h", $time, ftdi_data, exp_q[0]);
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // DRP address order, vaux4 then vaux12
    always @(posedge sys_clk) begin
        if (!rst_n) begin
            expect_volt = 1'b0;
        end else begin
            if (xadc_drdy)
                drdy_count++;
            if (xadc_den) begin
                if (xadc_daddr !== (expect_volt ? xadc_stream_pkg::VOLTAGE_DRP_ADDR
                                                : xadc_stream_pkg::CURRENT_DRP_ADDR)) begin
                    drp_err_count++;
                    $display("error at %0t: DRP address %h out of order", $time, xadc_daddr);
                end
                expect_volt = !expect_volt;
            end
        end
    end

    initial begin : stimulus
        logic [11:0] cur;
        logic [11:0] volt;
        int base;
        rst_n = 1'b0;
        eos_req = 1'b0;
        cur_code = 12'h000;
        volt_code = 12'h000;
        txe_mode = 2'd0;
        aborted = 1'b0;
        err_count = 0;
        timeout_count = 0;
        repeat (4) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(posedge sys_clk);
        if (ftdi_wr_n !== 1'b1 || overrun !== 1'b0) begin
            err_count++;
            $display("error at %0t: after reset wr_n=%b overrun=%b", $time, ftdi_wr_n, overrun);
        end
        repeat (10) @(posedge sys_clk);
        if (bytes_seen != 0 || drdy_count != 0) begin
            err_count++;
            $display("error at %0t: bus activity before the first eos", $time);
        end

        issue_sample(12'h5a3, 12'h7c1);  // no zero payload bytes
        wait_queue_below(1);

        issue_sample(12'h0ff, 12'h000);  // zero runs in the payload
        issue_sample(12'h000, 12'h000);
        issue_sample(12'h100, 12'h0a5);
        issue_sample(12'h000, 12'h801);
        wait_queue_below(1);

        txe_mode <= 2'd2;  // FTDI ready toggles at random
        for (int n = 0; n < 24; n++) begin
            cur  = 12'($random(seed));
            volt = 12'($random(seed));
            if (($random(seed) & 3) == 0)
                cur = cur & 12'h0ff;
            if (($random(seed) & 3) == 0)
                volt = volt & 12'h0ff;
            issue_sample(cur, volt);
            wait_queue_below(2 * FRAME_LEN + 1);  // keeps the fifo far from full
            repeat (1 + int'($unsigned($random(seed)) % 4)) @(posedge sys_clk);
        end
        txe_mode <= 2'd0;
        wait_queue_below(1);
        if (overrun !== 1'b0) begin
            err_count++;
            $display("error at %0t: overrun set without back-pressure", $time);
        end

        // FTDI stalled while more samples arrive than the fifo holds
        base = bytes_seen;
        txe_mode <= 2'd1;
        for (int n = 0; n < DEPTH + 3; n++)
            issue_sample(12'($random(seed)), 12'($random(seed)));
        txe_mode <= 2'd0;
        wait_quiet(16);
        if (overrun !== 1'b1) begin
            err_count++;
            $display("error at %0t: overrun low after fifo overflow", $time);
        end
        if ((bytes_seen - base) % FRAME_LEN != 0 || (bytes_seen - base) < DEPTH * FRAME_LEN ||
            exp_q.size() % FRAME_LEN != 0 || exp_q.size() == 0) begin
            err_count++;
            $display("error at %0t: %0d bytes delivered, %0d left undelivered", $time,
                     bytes_seen - base, exp_q.size());
        end
        exp_q.delete();

        $display("closing: %0d check errors, %0d byte errors, %0d DRP errors, %0d timeouts",
                 err_count, byte_err_count, drp_err_count, timeout_count);
        if (err_count + byte_err_count + drp_err_count + timeout_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: filelist.f
xadc_stream_pkg.sv
sample_fifo.sv
xadc_drp_poller.sv
ft_write_port.sv
cobs_packetizer.sv
xadc_usb_stream.sv
tb_xadc_model.sv
tb_xadc_usb_stream.sv

// File: Makefile
SIM = obj_dir/Vtb_xadc_usb_stream

.PHONY: all run clean

all: run

$(SIM): filelist.f $(shell cat filelist.f)
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_xadc_usb_stream --Mdir obj_dir -o Vtb_xadc_usb_stream

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
